/* design/stream_pkg.sv */
`default_nettype none

// Byte-stream types for the bulk OUT and bulk IN endpoint sides
package stream_pkg;

  // One data byte per beat
  typedef logic [7:0] byte_t;

  // A single stream beat. Keep is dropped since every beat carries
  // exactly one valid byte.
  typedef struct packed {
    byte_t data;
    logic  last;  // Final byte of a frame
  } stream_beat_t;

endpackage  // stream_pkg

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

// Word-memory types for the packer, controller, memory and unpacker
package mem_pkg;

  typedef logic [31:0] word_t;        // Byte 0 in the low lane
  typedef logic [1:0]  lane_count_t;  // Valid bytes in a word, minus one
  typedef logic [15:0] frame_len_t;   // Frame length in bytes

  // Word handed from the packer to the controller and memory
  typedef struct packed {
    word_t       data;
    lane_count_t count;
    logic        last;   // Word closes a frame
  } packed_word_t;

  // Read side of the controller
  typedef enum logic [1:0] {
    CTRL_IDLE,    // Waiting for a complete frame
    CTRL_FETCH,   // Read strobe to the memory
    CTRL_STREAM   // Word out, waiting for the unpacker
  } ctrl_state_t;

endpackage  // mem_pkg

`default_nettype wire

/* design/byte_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_packer
  import stream_pkg::*;
  import mem_pkg::*;
(
  input  wire          bus_clock,
  input  wire          rst_n_i,

  input  wire          s_valid_i,
  input  wire stream_beat_t s_beat_i,
  output logic         s_ready_o,

  input  wire          space_ok_i,
  output logic         wr_en_o,
  output packed_word_t wr_word_o
);

  word_t       data_q;
  lane_count_t lane_q;
  logic        fire;
  logic        word_done;

  assign s_ready_o = space_ok_i;
  assign fire      = s_valid_i && s_ready_o;
  assign word_done = fire && (s_beat_i.last || lane_q == 2'd3);

  always_ff @(posedge bus_clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lane_q  <= '0;
      data_q  <= '0;
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= word_done;
      if (fire) begin
        data_q[{lane_q, 3'b000} +: 8] <= s_beat_i.data;
        lane_q <= word_done ? '0 : lane_q + 1'b1;
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (word_done) begin
      wr_word_o.data  <= data_q;
      wr_word_o.data[{lane_q, 3'b000} +: 8] <= s_beat_i.data;
      wr_word_o.count <= lane_q;
      wr_word_o.last  <= s_beat_i.last;
    end
  end

endmodule  // byte_packer

`default_nettype wire

/* design/frame_store_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_store_ctrl
  import mem_pkg::*;
#(
  parameter int SRAM_WORDS  = 64,
  parameter int FRAME_SLOTS = 4
) (
  input  wire                                bus_clock,
  input  wire                                rst_n_i,

  // Write side, from the packer
  input  wire                                wr_en_i,
  input  wire packed_word_t                  wr_word_i,
  output logic                               space_ok_o,

  // Memory ports
  output logic                               rd_en_o,
  output logic [$clog2(SRAM_WORDS)-1:0]      rd_addr_o,
  output logic [$clog2(SRAM_WORDS)-1:0]      wr_addr_o,
  input  wire word_t                         rd_word_i,

  // Read side, to the unpacker
  output logic                               rd_word_valid_o,
  output word_t                              rd_word_o,
  output lane_count_t                        rd_count_o,
  output logic                               rd_last_o,
  input  wire                                word_taken_i,

  output logic [$clog2(FRAME_SLOTS+1)-1:0]   level_o
);

  localparam int AW  = $clog2(SRAM_WORDS);
  localparam int UW  = $clog2(SRAM_WORDS + 1);
  localparam int QW  = (FRAME_SLOTS > 1) ? $clog2(FRAME_SLOTS) : 1;
  localparam int QCW = $clog2(FRAME_SLOTS + 1);

  ctrl_state_t    state_q;
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [UW-1:0]  used_q;        // Words written and not yet fetched
  frame_len_t     len_q [FRAME_SLOTS];
  logic [QW-1:0]  q_wr_q;
  logic [QW-1:0]  q_rd_q;
  logic [QCW-1:0] q_count_q;
  frame_len_t     open_len_q;    // Bytes of the frame still arriving
  frame_len_t     bytes_left_q;  // Bytes of the head frame not yet fetched
  frame_len_t     word_bytes;
  frame_len_t     left_m1;
  logic           push;
  logic           pop;
  logic           fetch_d_q;

  function automatic logic [AW-1:0] addr_inc(input logic [AW-1:0] a);
    return (a == AW'(SRAM_WORDS - 1)) ? '0 : a + 1'b1;
  endfunction

  function automatic logic [QW-1:0] slot_inc(input logic [QW-1:0] s);
    return (s == QW'(FRAME_SLOTS - 1)) ? '0 : s + 1'b1;
  endfunction

  assign word_bytes = frame_len_t'(wr_word_i.count) + 1'b1;
  assign left_m1    = bytes_left_q - 1'b1;
  assign push       = wr_en_i && wr_word_i.last;
  assign pop        = (state_q == CTRL_STREAM) && word_taken_i && rd_last_o;

  // A write in flight already holds its slot. The next frame may start on
  // any beat, so a full length queue also blocks.
  assign space_ok_o = ((used_q + UW'(wr_en_i)) < UW'(SRAM_WORDS)) &&
                      ((q_count_q + QCW'(push)) < QCW'(FRAME_SLOTS));

  assign rd_en_o   = (state_q == CTRL_FETCH);
  assign rd_addr_o = rd_ptr_q;
  assign wr_addr_o = wr_ptr_q;
  assign level_o   = q_count_q;

  // Write pointer and open-frame byte count
  always_ff @(posedge bus_clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      q_wr_q     <= '0;
      open_len_q <= '0;
    end else if (wr_en_i) begin
      wr_ptr_q <= addr_inc(wr_ptr_q);
      if (wr_word_i.last) begin
        q_wr_q     <= slot_inc(q_wr_q);
        open_len_q <= '0;
      end else begin
        open_len_q <= open_len_q + word_bytes;
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (push) begin
      len_q[q_wr_q] <= open_len_q + word_bytes;  // Completed frame length
    end
  end

  always_ff @(posedge bus_clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      used_q    <= '0;
      q_count_q <= '0;
    end else begin
      used_q    <= used_q + UW'(wr_en_i) - UW'(rd_en_o);
      q_count_q <= q_count_q + QCW'(push) - QCW'(pop);
    end
  end

  // Read FSM, one word at a time from the head frame
  always_ff @(posedge bus_clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= CTRL_IDLE;
      rd_ptr_q     <= '0;
      q_rd_q       <= '0;
      bytes_left_q <= '0;
      rd_count_o   <= '0;
      rd_last_o    <= 1'b0;
    end else begin
      case (state_q)
        CTRL_IDLE: begin
          if (q_count_q != '0) begin
            bytes_left_q <= len_q[q_rd_q];
            state_q      <= CTRL_FETCH;
          end
        end
        CTRL_FETCH: begin
          rd_ptr_q <= addr_inc(rd_ptr_q);
          if (bytes_left_q > 16'd4) begin
            rd_count_o   <= 2'd3;
            rd_last_o    <= 1'b0;
            bytes_left_q <= bytes_left_q - 16'd4;
          end else begin
            rd_count_o   <= left_m1[1:0];  // Partial or full final word
            rd_last_o    <= 1'b1;
            bytes_left_q <= '0;
          end
          state_q <= CTRL_STREAM;
        end
        CTRL_STREAM: begin
          if (word_taken_i) begin
            if (rd_last_o) begin
              q_rd_q  <= slot_inc(q_rd_q);  // Frame fully replayed
              state_q <= CTRL_IDLE;
            end else begin
              state_q <= CTRL_FETCH;
            end
          end
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  // Data comes back the cycle after the strobe and is offered one later
  always_ff @(posedge bus_clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_d_q       <= 1'b0;
      rd_word_valid_o <= 1'b0;
    end else begin
      fetch_d_q       <= rd_en_o;
      rd_word_valid_o <= fetch_d_q;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (fetch_d_q) begin
      rd_word_o <= rd_word_i;
    end
  end

endmodule  // frame_store_ctrl

`default_nettype wire

/* design/word_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module word_sram
  import mem_pkg::*;
#(
  parameter int SRAM_WORDS = 64
) (
  input  wire                             bus_clock,

  input  wire                             wr_en_i,
  input  wire [$clog2(SRAM_WORDS)-1:0]    wr_addr_i,
  input  wire word_t                      wr_data_i,

  input  wire                             rd_en_i,
  input  wire [$clog2(SRAM_WORDS)-1:0]    rd_addr_i,
  output word_t                           rd_data_o
);

  // Stand-in for the DDR3 store
  word_t mem_q [SRAM_WORDS];

  always_ff @(posedge bus_clock) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read port, data valid the cycle after rd_en_i
  always_ff @(posedge bus_clock) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule  // word_sram

`default_nettype wire

/* design/byte_unpacker.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_unpacker
  import stream_pkg::*;
  import mem_pkg::*;
(
  input  wire               bus_clock,
  input  wire               rst_n_i,

  // Word side, from the controller
  input  wire               word_valid_i,
  input  wire word_t        word_i,
  input  wire lane_count_t  count_i,
  input  wire               last_i,
  output logic              word_taken_o,

  // Bulk IN byte stream
  output logic              m_valid_o,
  output stream_beat_t      m_beat_o,
  input  wire               m_ready_i
);

  word_t       word_q;
  lane_count_t count_q;
  lane_count_t lane_q;
  logic        last_q;
  logic        full_q;
  logic        fire;
  logic        final_lane;
  byte_t       lane_byte;

  assign final_lane   = (lane_q == count_q);
  assign fire         = full_q && m_ready_i;
  assign word_taken_o = fire && final_lane;  // Final byte of the word accepted

  assign lane_byte = word_q[{lane_q, 3'b000} +: 8];
  assign m_valid_o = full_q;
  assign m_beat_o  = '{data: lane_byte, last: last_q && final_lane};

  always_ff @(posedge bus_clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (word_valid_i) begin
      full_q <= 1'b1;  // Only arrives once the previous word is gone
      lane_q <= '0;
    end else if (fire) begin
      if (final_lane) begin
        full_q <= 1'b0;
      end else begin
        lane_q <= lane_q + 1'b1;
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (word_valid_i) begin
      word_q  <= word_i;
      count_q <= count_i;
      last_q  <= last_i;
    end
  end

endmodule  // byte_unpacker

`default_nettype wire

/* design/stream_store_top.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_store_top
  import stream_pkg::*;
  import mem_pkg::*;
#(
  parameter int SRAM_WORDS  = 64,
  parameter int FRAME_SLOTS = 4
) (
  input  wire                               bus_clock,
  input  wire                               rst_n_i,

  // From the bulk OUT endpoint
  input  wire                               s_valid_i,
  input  wire stream_beat_t                 s_beat_i,
  output logic                              s_ready_o,

  // To the bulk IN endpoint
  output logic                              m_valid_o,
  output stream_beat_t                      m_beat_o,
  input  wire                               m_ready_i,

  output logic [$clog2(FRAME_SLOTS+1)-1:0]  level_o   // Complete frames held
);

  packed_word_t                    wr_word;
  logic                            wr_en;
  logic                            space_ok;
  logic                            rd_en;
  logic [$clog2(SRAM_WORDS)-1:0]   rd_addr;
  logic [$clog2(SRAM_WORDS)-1:0]   wr_addr;
  word_t                           rd_data;
  word_t                           rd_word;
  lane_count_t                     rd_count;
  logic                            rd_word_valid;
  logic                            rd_last;
  logic                            word_taken;

  byte_packer u_packer (
      .bus_clock (bus_clock),
      .rst_n_i   (rst_n_i),
      .s_valid_i (s_valid_i),
      .s_beat_i  (s_beat_i),
      .s_ready_o (s_ready_o),
      .space_ok_i(space_ok),
      .wr_en_o   (wr_en),
      .wr_word_o (wr_word)
  );

  frame_store_ctrl #(
      .SRAM_WORDS (SRAM_WORDS),
      .FRAME_SLOTS(FRAME_SLOTS)
  ) u_ctrl (
      .bus_clock      (bus_clock),
      .rst_n_i        (rst_n_i),
      .wr_en_i        (wr_en),
      .wr_word_i      (wr_word),
      .space_ok_o     (space_ok),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr),
      .wr_addr_o      (wr_addr),
      .rd_word_i      (rd_data),
      .rd_word_valid_o(rd_word_valid),
      .rd_word_o      (rd_word),
      .rd_count_o     (rd_count),
      .rd_last_o      (rd_last),
      .word_taken_i   (word_taken),
      .level_o        (level_o)
  );

  word_sram #(
      .SRAM_WORDS(SRAM_WORDS)
  ) u_sram (
      .bus_clock(bus_clock),
      .wr_en_i  (wr_en),
      .wr_addr_i(wr_addr),
      .wr_data_i(wr_word.data),
      .rd_en_i  (rd_en),
      .rd_addr_i(rd_addr),
      .rd_data_o(rd_data)
  );

  byte_unpacker u_unpacker (
      .bus_clock   (bus_clock),
      .rst_n_i     (rst_n_i),
      .word_valid_i(rd_word_valid),
      .word_i      (rd_word),
      .count_i     (rd_count),
      .last_i      (rd_last),
      .word_taken_o(word_taken),
      .m_valid_o   (m_valid_o),
      .m_beat_o    (m_beat_o),
      .m_ready_i   (m_ready_i)
  );

endmodule  // stream_store_top

`default_nettype wire

/* test/stream_store_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_store_properties
  import stream_pkg::*;
#(
  parameter int FRAME_SLOTS = 4
) (
  input  wire                               bus_clock,
  input  wire                               rst_n_i,
  input  wire                               s_valid_i,
  input  wire stream_beat_t                 s_beat_i,
  input  wire                               s_ready_o,
  input  wire                               m_valid_o,
  input  wire stream_beat_t                 m_beat_o,
  input  wire                               m_ready_i,
  input  wire [$clog2(FRAME_SLOTS+1)-1:0]   level_o
);

  // Bulk OUT side, driven by the host model
  s_beat_held: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
      s_valid_i && !s_ready_o |=> s_valid_i && $stable(s_beat_i))
    else $error("Input beat changed or dropped before it was accepted");

  // Bulk IN side, driven by the unpacker
  m_beat_held: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o))
    else $error("Output beat changed or dropped before it was accepted");

  m_idle_in_reset: assert property (@(posedge bus_clock) !rst_n_i |-> !m_valid_o)
    else $error("m_valid_o high during reset");

  level_bounded: assert property (@(posedge bus_clock) disable iff (!rst_n_i)
      int'(level_o) <= FRAME_SLOTS)
    else $error("level_o above the number of frame slots");

endmodule  // stream_store_properties

bind stream_store_top stream_store_properties #(
    .FRAME_SLOTS(FRAME_SLOTS)
) u_props (
    .bus_clock(bus_clock),
    .rst_n_i  (rst_n_i),
    .s_valid_i(s_valid_i),
    .s_beat_i (s_beat_i),
    .s_ready_o(s_ready_o),
    .m_valid_o(m_valid_o),
    .m_beat_o (m_beat_o),
    .m_ready_i(m_ready_i),
    .level_o  (level_o)
);

`default_nettype wire

/* test/stream_store_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_store_checker
  import stream_pkg::*;
#(
  parameter int FRAME_SLOTS = 4
) (
  input  wire                               bus_clock,
  input  wire                               rst_n_i,
  input  wire                               s_valid_i,
  input  wire stream_beat_t                 s_beat_i,
  input  wire                               s_ready_o,
  input  wire                               m_valid_o,
  input  wire stream_beat_t                 m_beat_o,
  input  wire                               m_ready_i,
  input  wire [$clog2(FRAME_SLOTS+1)-1:0]   level_o
);

  stream_beat_t exp_q[$];      // Beats still owed by the DUT
  int           in_cycle_q[$]; // Cycle each input frame completed
  int cyc = 0;
  int in_done = 0;             // Frames fully accepted on the input
  int out_done = 0;            // Frames fully replayed
  int out_pos = 0;             // Byte index within the current output frame
  bit in_open = 1'b0;          // Input frame partly accepted
  int errors = 0;
  int test_errors = 0;
  int test_bytes = 0;
  int test_frames = 0;
  int tests_run = 0;
  int tests_failed = 0;

  function automatic void fail_value(input string msg);
    $display("FAIL @ %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endfunction

  function automatic void report_other(input string msg);
    $display("Error: %s", msg);
    errors++;
    test_errors++;
  endfunction

  function automatic void push_expected(input byte_t value, input logic is_last);
    exp_q.push_back('{data: value, last: is_last});
  endfunction

  function automatic int pending_bytes();
    return exp_q.size();
  endfunction

  function automatic int error_count();
    return errors;
  endfunction

  task automatic check_out(input stream_beat_t got);
    stream_beat_t want;
    if (exp_q.size() == 0) begin
      report_other($sformatf("output byte %02h at %0t ns with no frame pending", got.data,
                             $time));
      return;
    end
    if (out_pos == 0) begin
      if (in_cycle_q.size() == 0) begin
        report_other($sformatf("frame %0d began on the output before it was complete",
                               out_done));
      end else if (cyc - in_cycle_q[0] < 3) begin
        fail_value($sformatf("frame %0d replayed %0d cycles after its last input byte",
                             out_done, cyc - in_cycle_q[0]));
      end
    end
    want = exp_q.pop_front();
    if (got != want) begin
      fail_value($sformatf("frame %0d byte %0d got %02h last %0b, expected %02h last %0b",
                           out_done, out_pos, got.data, got.last, want.data, want.last));
    end
    test_bytes++;
    if (want.last) begin  // Follow the expected boundary to stay in step
      out_pos = 0;
      out_done++;
      test_frames++;
      if (in_cycle_q.size() != 0) begin
        void'(in_cycle_q.pop_front());
      end
    end else begin
      out_pos++;
    end
  endtask

  // Sample on the edge, before any NBA of this step lands
  always @(posedge bus_clock) begin
    int lvl_exp;
    if (rst_n_i) begin
      cyc++;
      if (cyc == 1) begin
        if (!s_ready_o) begin
          fail_value("s_ready_o low after reset, expected 1");
        end
        if (m_valid_o) begin
          fail_value("m_valid_o high after reset, expected 0");
        end
      end
      lvl_exp = in_done - out_done;
      // A completed frame shows in level_o one cycle after its last byte
      if (int'(level_o) > lvl_exp || int'(level_o) + 1 < lvl_exp) begin
        fail_value($sformatf("level_o is %0d, expected %0d", level_o, lvl_exp));
      end
      if (s_valid_i && s_ready_o) begin
        if (in_open && int'(level_o) == FRAME_SLOTS) begin
          fail_value("s_ready_o high inside a frame with every frame slot in use");
        end
        in_open = !s_beat_i.last;
      end
      if (s_valid_i && s_ready_o && s_beat_i.last) begin
        in_done++;
        in_cycle_q.push_back(cyc);
      end
      if (m_valid_o && m_ready_i) begin
        check_out(m_beat_o);
      end
    end
  end

  // Called on a falling edge once the test has drained
  task automatic end_test(input int id);
    if (m_valid_o) begin
      report_other($sformatf("test %0d left m_valid_o high after its last frame", id));
    end
    if (level_o != '0) begin
      fail_value($sformatf("level_o is %0d after test %0d, expected 0", level_o, id));
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d: %0d frames, %0d bytes, passed", id, test_frames, test_bytes);
    end else begin
      tests_failed++;
      $display("test %0d: %0d frames, %0d bytes, failed with %0d errors", id, test_frames,
               test_bytes, test_errors);
    end
    test_errors = 0;
    test_bytes  = 0;
    test_frames = 0;
  endtask

  task automatic print_summary();
    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
  endtask

endmodule  // stream_store_checker

`default_nettype wire

/* test/stream_store_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_store_tb
  import stream_pkg::*;
#(
  parameter int SRAM_WORDS  = 64,
  parameter int FRAME_SLOTS = 4
);

  localparam int LW = $clog2(FRAME_SLOTS + 1);

  logic          bus_clock;
  logic          rst_n_i;
  logic          s_valid_i;
  stream_beat_t  s_beat_i;
  logic          s_ready_o;
  logic          m_valid_o;
  stream_beat_t  m_beat_o;
  logic          m_ready_i;
  logic [LW-1:0] level_o;

  logic [15:0] vec [1024];   // Raw test records
  int duty = 100;            // Ready duty in percent, 0 holds ready low
  int limit_cycles = 0;

  stream_store_top #(
      .SRAM_WORDS (SRAM_WORDS),
      .FRAME_SLOTS(FRAME_SLOTS)
  ) uut (
      .bus_clock(bus_clock),
      .rst_n_i  (rst_n_i),
      .s_valid_i(s_valid_i),
      .s_beat_i (s_beat_i),
      .s_ready_o(s_ready_o),
      .m_valid_o(m_valid_o),
      .m_beat_o (m_beat_o),
      .m_ready_i(m_ready_i),
      .level_o  (level_o)
  );

  stream_store_checker #(
      .FRAME_SLOTS(FRAME_SLOTS)
  ) chk (
      .bus_clock(bus_clock),
      .rst_n_i  (rst_n_i),
      .s_valid_i(s_valid_i),
      .s_beat_i (s_beat_i),
      .s_ready_o(s_ready_o),
      .m_valid_o(m_valid_o),
      .m_beat_o (m_beat_o),
      .m_ready_i(m_ready_i),
      .level_o  (level_o)
  );

  initial begin
    bus_clock = 1'b0;
    forever #5 bus_clock = ~bus_clock;
  end

  // Output ready pattern, duty only changes on a falling edge
  initial begin
    forever begin
      @(posedge bus_clock);
      if (duty == 0) begin
        m_ready_i <= 1'b0;
      end else begin
        m_ready_i <= ($urandom % 100) < duty;
      end
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge bus_clock);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // Record size in words, mode 0 lists its bytes
  function automatic int frame_size(input int p);
    return (vec[p+1] == 16'd0) ? 2 + int'(vec[p]) : 4;
  endfunction

  function automatic byte_t frame_byte(input int p, input int i);
    if (vec[p+1] == 16'd0) begin
      return vec[p+2+i][7:0];
    end
    return byte_t'(int'(vec[p+2]) + i * int'(vec[p+3]));  // Ramp with wrap
  endfunction

  function automatic int count_bytes();
    int p;
    int total;
    int nf;
    p = 1;
    total = 0;
    for (int t = 0; t < int'(vec[0]); t++) begin
      nf = int'(vec[p+1]);
      p += 2;
      for (int f = 0; f < nf; f++) begin
        total += int'(vec[p]);
        p += frame_size(p);
      end
    end
    return total;
  endfunction

  task automatic send_beat(input byte_t value, input logic is_last);
    logic taken;
    s_valid_i <= 1'b1;
    s_beat_i  <= '{data: value, last: is_last};
    do begin
      @(negedge bus_clock);
      taken = s_ready_o;
      @(posedge bus_clock);
    end while (!taken);
  endtask

  task automatic send_frames(input int first, input int nframes);
    int p;
    int len;
    p = first;
    for (int f = 0; f < nframes; f++) begin
      len = int'(vec[p]);
      for (int i = 0; i < len; i++) begin
        send_beat(frame_byte(p, i), i == len - 1);
      end
      p += frame_size(p);
    end
    s_valid_i <= 1'b0;
  endtask

  // Let ready go once the store is full and the input is blocked
  task automatic release_ready();
    do @(negedge bus_clock); while (!(level_o == LW'(FRAME_SLOTS) && !s_ready_o));
    repeat (8) @(negedge bus_clock);
    duty = 100;
  endtask

  task automatic run_test(input int id, inout int ptr);
    int nframes;
    int len;
    int first;
    @(negedge bus_clock);
    duty    = int'(vec[ptr]);
    nframes = int'(vec[ptr+1]);
    ptr += 2;
    first = ptr;
    for (int f = 0; f < nframes; f++) begin
      len = int'(vec[ptr]);
      for (int i = 0; i < len; i++) begin
        chk.push_expected(frame_byte(ptr, i), i == len - 1);
      end
      ptr += frame_size(ptr);
    end
    @(posedge bus_clock);
    fork
      send_frames(first, nframes);
      if (duty == 0) release_ready();
    join
    do @(negedge bus_clock); while (chk.pending_bytes() != 0);
    repeat (20) @(negedge bus_clock);  // Room for a repeated byte to show up
    chk.end_test(id);
  endtask

  initial begin
    int ntests;
    int ptr;
    rst_n_i   = 1'b0;
    s_valid_i = 1'b0;
    s_beat_i  = '0;
    m_ready_i = 1'b0;
    void'($urandom(32'hd29938eb));
    $readmemh("test/stream_store_tests.txt", vec);
    ntests = int'(vec[0]);
    limit_cycles = count_bytes() * 20 + 2000;
    repeat (4) @(posedge bus_clock);
    rst_n_i <= 1'b1;
    if (ntests == 0) begin
      chk.report_other("no tests found in test/stream_store_tests.txt");
    end
    ptr = 1;
    for (int t = 0; t < ntests; t++) begin
      run_test(t + 1, ptr);
    end
    chk.print_summary();
    if (chk.error_count() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule  // stream_store_tb

`default_nettype wire

/* test/stream_store_tests.txt */
// First word is the test count. A test opens with <ready duty %> <frame count>,
// duty 0 holds m_ready_i low until the store is full.
// A frame is <length> <mode>, then the bytes (mode 0) or <start> <step> (mode 1).
0007
// Single frames with partial and full words
0064 0001
0001 0000 a5
0064 0001
0003 0000 11 22 33
0064 0001
0004 0000 de ad be ef
0064 0001
0009 0000 01 02 03 04 05 06 07 08 09
// Back to back frames at half ready
0032 0004
0002 0000 aa 55
0005 0001 10 03
0001 0000 7e
0008 0001 f0 11
// Ready held low until the length queue fills
0000 0005
0006 0001 20 01
0003 0000 c1 c2 c3
0007 0001 40 05
0004 0000 9a 9b 9c 9d
000a 0001 80 07
// Large frames with random ready
0028 0003
00c8 0001 03 07
0040 0001 55 0b
0060 0001 00 01

/* src.f */
design/stream_pkg.sv
design/mem_pkg.sv
design/byte_packer.sv
design/frame_store_ctrl.sv
design/word_sram.sv
design/byte_unpacker.sv
design/stream_store_top.sv
test/stream_store_properties.sv
test/stream_store_checker.sv
test/stream_store_tb.sv

/* Makefile */
# Verilator build for the stream store testbench

VERILATOR ?= verilator
TOP       ?= stream_store_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT ?= RESULT: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the run prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
